//--- all.f
+incdir+rtl
rtl/alut_entry_pkg.sv
rtl/alut_ctrl_pkg.sv
rtl/alut_mem.sv
rtl/alut_addr_checker.sv
rtl/alut_age_checker.sv
rtl/alut_top.sv
sim/alut_sva.sv
sim/alut_tb.sv

//--- rtl/alut_addr_checker.sv
// lookup and learn engine of the address table
// takes one request at a time, reads the destination slot, learns the
// source slot with the current time and holds the answer until taken
`timescale 1ns/1ps
`include "alut_defs.svh"

module alut_addr_checker
(
   input  logic                    pclk10,
   input  logic                    arst_n,
   // request handshake
   input  logic                    req_valid,
   output logic                    req_ready,
   input  alut_entry_pkg::mac_t    src_mac,
   input  alut_entry_pkg::mac_t    dst_mac,
   input  alut_entry_pkg::port_t   src_port,
   // response handshake
   output logic                    resp_valid,
   input  logic                    resp_ready,
   output alut_entry_pkg::port_t   resp_port,
   output logic                    resp_hit,
   // age checker side
   input  alut_entry_pkg::tstamp_t curr_time,
   input  logic                    age_busy,
   output logic                    addr_busy,
   // table port a
   output alut_entry_pkg::idx_t    mem_addr_add,
   output logic                    mem_write_add,
   output alut_entry_pkg::entry_t  mem_write_data_add,
   input  alut_entry_pkg::entry_t  mem_read_data_add
);

   alut_ctrl_pkg::addr_state_t state;      // current state
   alut_ctrl_pkg::addr_state_t state_nxt;

   alut_entry_pkg::mac_t  src_q;           // captured request
   alut_entry_pkg::mac_t  dst_q;
   alut_entry_pkg::port_t port_q;
   alut_entry_pkg::idx_t  src_idx;         // hashed slots
   alut_entry_pkg::idx_t  dst_idx;
   alut_entry_pkg::port_t resp_port_q;     // held answer
   logic                  hit_q;
   logic                  accept;          // request transfers this edge
   logic                  dst_match;
   logic                  run_q;           // set on the first edge out of reset

   // ----------------------------------------
   // handshakes and busy flag
   // ----------------------------------------
   // ready stays low through reset and its release edge
   always_ff @(posedge pclk10 or negedge arst_n)
   begin
      if (!arst_n)
         run_q <= 1'b0;
      else
         run_q <= 1'b1;
   end

   // a sweep step in flight blocks new requests
   assign req_ready = run_q && (state == alut_ctrl_pkg::ADD_IDLE) && !age_busy;
   assign accept    = req_valid && req_ready;

   // busy also covers the accept cycle so the sweep never starts
   // a step alongside a fresh lookup
   assign addr_busy = (state != alut_ctrl_pkg::ADD_IDLE) || accept;

   assign resp_valid = (state == alut_ctrl_pkg::ADD_RESP);
   assign resp_port  = resp_port_q;
   assign resp_hit   = hit_q;

   // ----------------------------------------
   // hashing and compare
   // ----------------------------------------
   assign src_idx = alut_entry_pkg::hash(src_q);
   assign dst_idx = alut_entry_pkg::hash(dst_q);

   assign dst_match = alut_entry_pkg::entry_valid(mem_read_data_add) &&
                      (alut_entry_pkg::entry_mac(mem_read_data_add) == dst_q);

   // ----------------------------------------
   // fsm
   // ----------------------------------------
   always_comb
   begin
      state_nxt = state;
      case (state)
         alut_ctrl_pkg::ADD_IDLE:
         begin
            if (accept)
               state_nxt = alut_ctrl_pkg::ADD_RD_DST;
         end
         alut_ctrl_pkg::ADD_RD_DST: state_nxt = alut_ctrl_pkg::ADD_CMP;   // data next edge
         alut_ctrl_pkg::ADD_CMP:    state_nxt = alut_ctrl_pkg::ADD_LEARN;
         alut_ctrl_pkg::ADD_LEARN:  state_nxt = alut_ctrl_pkg::ADD_RESP;
         alut_ctrl_pkg::ADD_RESP:
         begin
            if (resp_ready)          // wait out back-pressure
               state_nxt = alut_ctrl_pkg::ADD_IDLE;
         end
         default:                   state_nxt = alut_ctrl_pkg::ADD_IDLE;
      endcase
   end

   always_ff @(posedge pclk10 or negedge arst_n)
   begin
      if (!arst_n)
         state <= alut_ctrl_pkg::ADD_IDLE;
      else
         state <= state_nxt;
   end

   // request fields, taken on the accept edge
   always_ff @(posedge pclk10)
   begin
      if (accept)
      begin
         src_q  <= src_mac;
         dst_q  <= dst_mac;
         port_q <= src_port;
      end
   end

   // answer is settled in cmp, before the learn write lands
   always_ff @(posedge pclk10 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         hit_q       <= 1'b0;
         resp_port_q <= `ALUT_BCAST_PORT;
      end
      else if (state == alut_ctrl_pkg::ADD_CMP)
      begin
         if (dst_match)
         begin
            hit_q       <= 1'b1;
            resp_port_q <= alut_entry_pkg::entry_port(mem_read_data_add);
         end
         else
         begin
            hit_q       <= 1'b0;             // unknown so flood it
            resp_port_q <= `ALUT_BCAST_PORT;
         end
      end
   end

   // ----------------------------------------
   // table port a
   // ----------------------------------------
   // learn writes the source slot and every other state reads the destination
   assign mem_addr_add  = (state == alut_ctrl_pkg::ADD_LEARN) ? src_idx : dst_idx;
   assign mem_write_add = (state == alut_ctrl_pkg::ADD_LEARN);
   assign mem_write_data_add = alut_entry_pkg::make_entry(1'b1, port_q, curr_time, src_q);

endmodule

//--- rtl/alut_age_checker.sv
// time base and background aging sweep of the address table
// walks every slot in turn and clears valid on entries whose age
// is beyond age_limit, stepping only while the lookup engine is idle
`timescale 1ns/1ps
`include "alut_defs.svh"

module alut_age_checker
(
   input  logic                    pclk10,
   input  logic                    arst_n,
   input  logic                    sweep_en,      // run the sweep
   input  alut_entry_pkg::tstamp_t age_limit,     // in ticks
   input  logic                    addr_busy,
   output logic                    age_busy,
   output alut_entry_pkg::tstamp_t curr_time,
   // table port b
   output alut_entry_pkg::idx_t    mem_addr_age,
   output logic                    mem_write_age,
   output alut_entry_pkg::entry_t  mem_write_data_age,
   input  alut_entry_pkg::entry_t  mem_read_data_age
);

   alut_ctrl_pkg::age_state_t state;
   alut_ctrl_pkg::age_state_t state_nxt;

   logic [$clog2(`ALUT_TICK)-1:0] tick_cnt;    // prescaler
   logic                          tick_wrap;
   alut_entry_pkg::tstamp_t       time_q;      // timestamp counter
   alut_entry_pkg::idx_t          sweep_idx;   // slot under test
   alut_entry_pkg::tstamp_t       entry_age;
   alut_entry_pkg::entry_t        ent_q;       // slot contents from rd
   logic                          expire_q;

   // ----------------------------------------
   // time base
   // ----------------------------------------
   assign tick_wrap = (tick_cnt == ($clog2(`ALUT_TICK))'(`ALUT_TICK - 1));

   always_ff @(posedge pclk10 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         tick_cnt <= '0;
         time_q   <= '0;
      end
      else if (tick_wrap)
      begin
         tick_cnt <= '0;
         time_q   <= time_q + 1'b1;   // wraps at 2^31
      end
      else
         tick_cnt <= tick_cnt + 1'b1;
   end

   assign curr_time = time_q;

   // ----------------------------------------
   // sweep fsm
   // ----------------------------------------
   always_comb
   begin
      state_nxt = state;
      case (state)
         alut_ctrl_pkg::AGE_IDLE:
         begin
            if (sweep_en && !addr_busy)   // lookups win
               state_nxt = alut_ctrl_pkg::AGE_RD;
         end
         alut_ctrl_pkg::AGE_RD:  state_nxt = alut_ctrl_pkg::AGE_CHK;
         alut_ctrl_pkg::AGE_CHK: state_nxt = alut_ctrl_pkg::AGE_WR;
         default:                state_nxt = alut_ctrl_pkg::AGE_IDLE;  // after wr
      endcase
   end

   always_ff @(posedge pclk10 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state     <= alut_ctrl_pkg::AGE_IDLE;
         sweep_idx <= '0;
      end
      else
      begin
         state <= state_nxt;
         if (state == alut_ctrl_pkg::AGE_WR)
            sweep_idx <= sweep_idx + 1'b1;   // 255 rolls to 0
      end
   end

   assign age_busy = (state != alut_ctrl_pkg::AGE_IDLE);

   // ----------------------------------------
   // age check
   // ----------------------------------------
   // modulo 2^31 difference, so a wrapped clock still ages right
   assign entry_age = curr_time - alut_entry_pkg::entry_time(mem_read_data_age);

   // anything not provably valid and young gets valid cleared,
   // which also scrubs slots never written since power up
   always_ff @(posedge pclk10 or negedge arst_n)
   begin
      if (!arst_n)
         expire_q <= 1'b0;
      else if (state == alut_ctrl_pkg::AGE_CHK)
      begin
         if (alut_entry_pkg::entry_valid(mem_read_data_age) && (entry_age <= age_limit))
            expire_q <= 1'b0;   // keep
         else
            expire_q <= 1'b1;
      end
   end

   always_ff @(posedge pclk10)
   begin
      if (state == alut_ctrl_pkg::AGE_CHK)
         ent_q <= mem_read_data_age;
   end

   // ----------------------------------------
   // table port b
   // ----------------------------------------
   assign mem_addr_age  = sweep_idx;
   assign mem_write_age = (state == alut_ctrl_pkg::AGE_WR) && expire_q;
   assign mem_write_data_age = alut_entry_pkg::make_entry(1'b0,
                                  alut_entry_pkg::entry_port(ent_q),
                                  alut_entry_pkg::entry_time(ent_q),
                                  alut_entry_pkg::entry_mac(ent_q));

endmodule

//--- rtl/alut_ctrl_pkg.sv
// state encodings of the two table checkers
// the lookup engine and the sweep each own one of these machines
package alut_ctrl_pkg;

   // ----------------------------------------
   // lookup and learn engine
   // ----------------------------------------
   typedef enum logic [2:0] {
      ADD_IDLE   = 3'd0,  // waiting for a request
      ADD_RD_DST = 3'd1,  // read destination slot
      ADD_CMP    = 3'd2,  // compare returned entry
      ADD_LEARN  = 3'd3,  // write source slot
      ADD_RESP   = 3'd4   // hold response until taken
   } addr_state_t;

   // ----------------------------------------
   // background aging sweep
   // ----------------------------------------
   typedef enum logic [1:0] {
      AGE_IDLE = 2'd0,    // between steps
      AGE_RD   = 2'd1,    // read current index
      AGE_CHK  = 2'd2,    // work out the age
      AGE_WR   = 2'd3     // clear valid if stale
   } age_state_t;

endpackage

//--- rtl/alut_defs.svh
// sizes and constants shared by the address lookup table
// pulled in by both packages and by modules that size storage or timing
`ifndef ALUT_DEFS_SVH
`define ALUT_DEFS_SVH

// ----------------------------------------
// table geometry
// ----------------------------------------
`define ALUT_DW 83       // valid + port + timestamp + mac
`define ALUT_DD 256      // entries in the table
`define ALUT_IW 8        // index bits, log2 of depth

// field widths inside an entry
`define ALUT_MW 48       // mac address
`define ALUT_PW 3        // switch port number
`define ALUT_TW 31       // timestamp in ticks

// ----------------------------------------
// timing and special values
// ----------------------------------------
`define ALUT_TICK 16     // pclk10 cycles per timestamp step

// port given back when the destination is unknown
`define ALUT_BCAST_PORT 3'd7

`endif

//--- rtl/alut_entry_pkg.sv
// entry level types of the lookup table and the helpers that
// pick an entry apart, so every block agrees on field positions
package alut_entry_pkg;
`include "alut_defs.svh"

   typedef logic [`ALUT_MW-1:0] mac_t;    // station address
   typedef logic [`ALUT_PW-1:0] port_t;   // switch port
   typedef logic [`ALUT_TW-1:0] tstamp_t; // time in ticks
   typedef logic [`ALUT_IW-1:0] idx_t;    // table index
   typedef logic [`ALUT_DW-1:0] entry_t;  // {valid, port, time, mac}

   // fold the six mac bytes into one index
   function automatic idx_t hash(input mac_t mac);
      idx_t h;
      h = '0;
      for (int i = 0; i < 6; i++)
      begin
         h = h ^ mac[8*i +: 8];
      end
      return h;
   endfunction

   function automatic logic entry_valid(input entry_t e);
      return e[`ALUT_DW-1];                  // top bit
   endfunction

   function automatic port_t entry_port(input entry_t e);
      return e[`ALUT_DW-2 -: `ALUT_PW];
   endfunction

   function automatic tstamp_t entry_time(input entry_t e);
      return e[`ALUT_MW +: `ALUT_TW];
   endfunction

   function automatic mac_t entry_mac(input entry_t e);
      return e[`ALUT_MW-1:0];                // low bits
   endfunction

   function automatic entry_t make_entry(input logic v, input port_t p,
                                         input tstamp_t t, input mac_t m);
      return {v, p, t, m};
   endfunction

endpackage

//--- rtl/alut_mem.sv
// dual port table ram, port a for lookups and port b for the sweep
// each port either writes or does a registered read every cycle
`timescale 1ns/1ps
`include "alut_defs.svh"

module alut_mem
(
   input  logic                   pclk10,
   // lookup engine side
   input  alut_entry_pkg::idx_t   mem_addr_add,
   input  logic                   mem_write_add,       // high = write
   input  alut_entry_pkg::entry_t mem_write_data_add,
   // sweep side
   input  alut_entry_pkg::idx_t   mem_addr_age,
   input  logic                   mem_write_age,       // high = write
   input  alut_entry_pkg::entry_t mem_write_data_age,
   // read data, one cycle after the address
   output alut_entry_pkg::entry_t mem_read_data_add,
   output alut_entry_pkg::entry_t mem_read_data_age
);

   alut_entry_pkg::entry_t mem_core [`ALUT_DD];  // storage, no reset

   // ----------------------------------------
   // port a
   // ----------------------------------------
   always @(posedge pclk10)
   begin
      if (!mem_write_add)
         mem_read_data_add <= mem_core[mem_addr_add];  // read
      else
         mem_core[mem_addr_add] <= mem_write_data_add;
   end

   // ----------------------------------------
   // port b
   // ----------------------------------------
   always @(posedge pclk10)
   begin
      if (!mem_write_age)
         mem_read_data_age <= mem_core[mem_addr_age];  // read
      else
         mem_core[mem_addr_age] <= mem_write_data_age;
   end

endmodule

//--- rtl/alut_top.sv
// address lookup table subsystem
// lookup engine and aging sweep sharing one dual port table ram
`timescale 1ns/1ps

module alut_top
(
   input  logic                    pclk10,
   input  logic                    arst_n,
   // sweep control
   input  logic                    sweep_en,
   input  alut_entry_pkg::tstamp_t age_limit,
   // request
   input  logic                    req_valid,
   output logic                    req_ready,
   input  alut_entry_pkg::mac_t    src_mac,
   input  alut_entry_pkg::mac_t    dst_mac,
   input  alut_entry_pkg::port_t   src_port,
   // response
   output logic                    resp_valid,
   input  logic                    resp_ready,
   output alut_entry_pkg::port_t   resp_port,
   output logic                    resp_hit
);

   // ----------------------------------------
   // checker to checker
   // ----------------------------------------
   logic                    addr_busy;
   logic                    age_busy;
   alut_entry_pkg::tstamp_t curr_time;

   // ----------------------------------------
   // ram ports
   // ----------------------------------------
   alut_entry_pkg::idx_t    mem_addr_add;
   logic                    mem_write_add;
   alut_entry_pkg::entry_t  mem_write_data_add;
   alut_entry_pkg::entry_t  mem_read_data_add;
   alut_entry_pkg::idx_t    mem_addr_age;
   logic                    mem_write_age;
   alut_entry_pkg::entry_t  mem_write_data_age;
   alut_entry_pkg::entry_t  mem_read_data_age;

   alut_addr_checker u_addr_checker
   (
      .pclk10, .arst_n,
      .req_valid, .req_ready, .src_mac, .dst_mac, .src_port,
      .resp_valid, .resp_ready, .resp_port, .resp_hit,
      .curr_time, .age_busy, .addr_busy,
      .mem_addr_add, .mem_write_add, .mem_write_data_add, .mem_read_data_add
   );

   alut_age_checker u_age_checker
   (
      .pclk10, .arst_n,
      .sweep_en, .age_limit, .addr_busy, .age_busy, .curr_time,
      .mem_addr_age, .mem_write_age, .mem_write_data_age, .mem_read_data_age
   );

   alut_mem u_mem
   (
      .pclk10,
      .mem_addr_add, .mem_write_add, .mem_write_data_add,
      .mem_addr_age, .mem_write_age, .mem_write_data_age,
      .mem_read_data_add, .mem_read_data_age
   );

endmodule

//--- sim/alut_sva.sv
// concurrent checks on the lookup table handshakes and ram ports
// bound into alut_top by the bind statement at the end of this file
`timescale 1ns/1ps

module alut_sva
(
   input logic                  pclk10,
   input logic                  arst_n,
   input logic                  req_valid,
   input logic                  req_ready,
   input logic                  resp_valid,
   input logic                  resp_ready,
   input alut_entry_pkg::port_t resp_port,
   input logic                  resp_hit,
   input logic                  mem_write_add,   // ram port a write
   input logic                  mem_write_age    // ram port b write
);

   int unsigned fail_cnt = 0;   // read by the testbench at the end

   // ----------------------------------------
   // reset behavior
   // ----------------------------------------
   reset_quiet: assert property (@(posedge pclk10)
      !arst_n |-> !req_ready && !resp_valid && !mem_write_add && !mem_write_age)
   else
   begin
      $error("ready, response or ram write active while reset is held");
      fail_cnt++;
   end

   // nothing pending yet on the first edge out of reset
   release_quiet: assert property (@(posedge pclk10)
      $rose(arst_n) |-> !req_ready && !resp_valid && !mem_write_add && !mem_write_age)
   else
   begin
      $error("ready, response or ram write active at reset release");
      fail_cnt++;
   end

   // ----------------------------------------
   // handshakes
   // ----------------------------------------
   // response frozen under back-pressure
   resp_hold: assert property (@(posedge pclk10) disable iff (!arst_n)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp_port) && $stable(resp_hit))
   else
   begin
      $error("response dropped or changed before it was taken");
      fail_cnt++;
   end

   no_accept_in_resp: assert property (@(posedge pclk10) disable iff (!arst_n)
      resp_valid |-> !req_ready)   // one request in flight
   else
   begin
      $error("req_ready high while a response is pending");
      fail_cnt++;
   end

   // accept edge to first resp_valid cycle is 4 cycles
   resp_latency: assert property (@(posedge pclk10) disable iff (!arst_n)
      req_valid && req_ready |=> !resp_valid [*3] ##1 resp_valid)
   else
   begin
      $error("resp_valid not exactly 4 cycles after accept");
      fail_cnt++;
   end

   // the two checkers never write in the same cycle
   one_writer: assert property (@(posedge pclk10) disable iff (!arst_n)
      !(mem_write_add && mem_write_age))
   else
   begin
      $error("both ram ports write in the same cycle");
      fail_cnt++;
   end

endmodule

bind alut_top alut_sva u_sva
(
   .pclk10        (pclk10),
   .arst_n        (arst_n),
   .req_valid     (req_valid),
   .req_ready     (req_ready),
   .resp_valid    (resp_valid),
   .resp_ready    (resp_ready),
   .resp_port     (resp_port),
   .resp_hit      (resp_hit),
   .mem_write_add (mem_write_add),
   .mem_write_age (mem_write_age)
);

//--- sim/alut_tb.sv
// testbench for the address lookup table subsystem
// drives lookups through alut_top and checks each answer against a
// reference table, concurrent checks come from the bound alut_sva
`timescale 1ns/1ps
`include "alut_defs.svh"

module alut_tb;

   localparam int TIMEOUT = 64;   // cycles per handshake wait

   logic                    pclk10;
   logic                    arst_n;
   logic                    sweep_en;
   alut_entry_pkg::tstamp_t age_limit;
   logic                    req_valid;
   logic                    req_ready;
   alut_entry_pkg::mac_t    src_mac;
   alut_entry_pkg::mac_t    dst_mac;
   alut_entry_pkg::port_t   src_port;
   logic                    resp_valid;
   logic                    resp_ready;
   alut_entry_pkg::port_t   resp_port;
   logic                    resp_hit;

   // reference table, indexed by the folded mac
   logic                    m_valid [`ALUT_DD];
   alut_entry_pkg::mac_t    m_mac   [`ALUT_DD];
   alut_entry_pkg::port_t   m_port  [`ALUT_DD];

   int pass_cnt = 0;
   int fail_cnt = 0;
   int err_mark = 0;    // error total at start of current test
   int req_cnt  = 0;

   alut_entry_pkg::mac_t pool [12];   // random traffic addresses

   localparam alut_entry_pkg::mac_t MAC_A    = 48'h02_00_00_00_00_11;   // slot 0x13
   localparam alut_entry_pkg::mac_t MAC_B    = 48'h02_00_00_00_00_44;   // slot 0x46
   localparam alut_entry_pkg::mac_t MAC_C    = 48'h02_00_00_00_00_22;   // slot 0x20
   localparam alut_entry_pkg::mac_t MAC_MISS = 48'h02_00_00_00_00_33;   // never learned

   alut_top dut
   (
      .pclk10, .arst_n, .sweep_en, .age_limit,
      .req_valid, .req_ready, .src_mac, .dst_mac, .src_port,
      .resp_valid, .resp_ready, .resp_port, .resp_hit
   );

   always #20 pclk10 = ~pclk10;   // 40 ns period

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   // xor of the six bytes
   function automatic logic [7:0] fold_mac(input alut_entry_pkg::mac_t mac);
      return mac[47:40] ^ mac[39:32] ^ mac[31:24] ^ mac[23:16] ^ mac[15:8] ^ mac[7:0];
   endfunction

   function automatic int total_errors();
      return fail_cnt + dut.u_sva.fail_cnt;
   endfunction

   // step to 2 ns past the next rising edge
   task automatic next_cycle();
      @(posedge pclk10);
      #2;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic clear_model();
      for (int i = 0; i < `ALUT_DD; i++)
      begin
         m_valid[i] = 1'b0;
         m_mac[i]   = '0;
         m_port[i]  = '0;
      end
   endtask

   task automatic compare_field(input string name, input logic [47:0] exp,
                                input logic [47:0] got);
      assert (got === exp)
         pass_cnt++;
      else
      begin
         $display("** Error: %s expected 0x%0h got 0x%0h (request %0d)",
                  name, exp, got, req_cnt);
         fail_cnt++;
      end
   endtask

   // one lookup, stall = cycles resp_ready is held low
   task automatic do_request(input alut_entry_pkg::mac_t s, input alut_entry_pkg::mac_t d,
                             input alut_entry_pkg::port_t p, input int stall);
      logic [7:0]            d_idx;
      logic [7:0]            s_idx;
      logic                  exp_hit;
      alut_entry_pkg::port_t exp_port;
      int                    n;
      d_idx    = fold_mac(d);
      s_idx    = fold_mac(s);
      exp_hit  = m_valid[d_idx] && (m_mac[d_idx] == d);   // table before own learn
      exp_port = exp_hit ? m_port[d_idx] : `ALUT_BCAST_PORT;
      req_cnt++;

      src_mac    = s;
      dst_mac    = d;
      src_port   = p;
      req_valid  = 1'b1;
      resp_ready = (stall == 0);
      n = 0;
      while (!req_ready && n < TIMEOUT)   // sweep step may be in flight
      begin
         next_cycle();
         n++;
      end
      if (!req_ready)
      begin
         $display("request %0d: req_ready never came high, request dropped", req_cnt);
         fail_cnt++;
         req_valid = 1'b0;
      end
      else
      begin
         next_cycle();                    // accept edge
         req_valid = 1'b0;
         n = 0;
         while (!resp_valid && n < TIMEOUT)
         begin
            next_cycle();
            n++;
         end
         if (!resp_valid)
         begin
            $display("request %0d: resp_valid never came after the accept", req_cnt);
            fail_cnt++;
         end
         else
         begin
            compare_field("resp_hit", exp_hit, resp_hit);
            compare_field("resp_port", exp_port, resp_port);
            if (stall > 0)
            begin
               repeat (stall) next_cycle();    // held off
               compare_field("resp_port", exp_port, resp_port);
               resp_ready = 1'b1;
            end
            next_cycle();                       // response taken
         end
         m_valid[s_idx] = 1'b1;                 // collision just overwrites
         m_mac[s_idx]   = s;
         m_port[s_idx]  = p;
      end
   endtask

   task automatic finish_test(input int num, input string name);
      int errs;
      errs = total_errors() - err_mark;
      if (errs == 0)
         $display("test %0d %s: passed", num, name);
      else
         $display("test %0d %s: failed with %0d errors", num, name, errs);
      err_mark = total_errors();
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial
   begin
      int stall;
      void'($urandom(36));
      pclk10     = 1'b0;
      arst_n     = 1'b1;
      sweep_en   = 1'b0;
      age_limit  = '0;
      req_valid  = 1'b0;
      resp_ready = 1'b1;
      src_mac    = '0;
      dst_mac    = '0;
      src_port   = '0;
      clear_model();

      #2 arst_n = 1'b0;                 // clean falling edge
      repeat (4) @(posedge pclk10);
      #2 arst_n = 1'b1;
      next_cycle();
      finish_test(1, "reset state");

      // scrub the uninitialized table, limit 0 expires all
      sweep_en  = 1'b1;
      age_limit = '0;
      idle_cycles(1100);                // one sweep is 256 x 4 cycles
      age_limit = '1;

      do_request(MAC_C, MAC_MISS, 3'd1, 0);
      finish_test(2, "miss");

      do_request(MAC_A, MAC_C, 3'd3, 0);     // hit on c
      do_request(MAC_C, MAC_A, 3'd1, 0);     // hit on a, port 3
      do_request(MAC_A, MAC_MISS, 3'd5, 0);  // relearn a on 5
      do_request(MAC_C, MAC_A, 3'd1, 0);
      finish_test(3, "learn then hit");

      sweep_en = 1'b0;
      idle_cycles(4);                        // let a step finish
      for (int k = 0; k < 4; k++)
      begin
         stall = $urandom_range(12, 1);
         do_request(MAC_A, MAC_C, 3'(k), stall);
      end
      sweep_en = 1'b1;
      finish_test(4, "back-pressure");

      do_request(MAC_B, MAC_A, 3'd6, 0);
      age_limit = 31'd2;
      idle_cycles(2200);                     // two sweeps plus 3 ticks
      clear_model();
      do_request(MAC_C, MAC_B, 3'd4, 0);     // b must be gone
      age_limit = '1;
      finish_test(5, "aging");

      for (int k = 0; k < 11; k++)
      begin
         pool[k] = {16'($urandom), $urandom};
      end
      pool[11] = pool[0] ^ 48'h0000_0000_5a5a;   // same slot as pool[0]
      for (int k = 0; k < 200; k++)
      begin
         stall = ($urandom_range(7, 0) == 0) ? $urandom_range(4, 1) : 0;
         do_request(pool[$urandom_range(11, 0)], pool[$urandom_range(11, 0)],
                    3'($urandom_range(7, 0)), stall);
      end
      finish_test(6, "random traffic");

      $display("summary: %0d checks passed, %0d checks failed, %0d assertion failures",
               pass_cnt, fail_cnt, dut.u_sva.fail_cnt);
      if (total_errors() == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule
